//--- verif/rename_patterns.txt
// test ctl(b0 ren b1 resteer b2 flush b3 cmp) slot hasrd rd0-1 rs1_0-1 rs2_0-1, then commit:
// cvld crd0-1 cprd0-1 cold0-1, expected: rdy prd0-1 prs1_0-1 prs2_0-1 old0-1; test ff ends
01 09 03 03 01 02 03 04 05 06  00 00 00 00 00 00 00  01 20 21 03 04 05 06 01 02
02 09 03 03 03 03 01 03 02 01  00 00 00 00 00 00 00  01 22 23 20 22 21 20 03 22
02 09 03 03 04 05 03 04 03 03  00 00 00 00 00 00 00  01 24 25 23 24 23 23 04 05
03 09 03 02 07 06 05 07 04 00  00 00 00 00 00 00 00  01 00 26 25 07 24 00 07 06
03 09 03 00 00 00 06 01 02 03  00 00 00 00 00 00 00  01 00 00 26 20 21 23 00 00
04 01 03 03 08 09 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00
04 01 03 03 08 09 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00
04 01 03 03 08 09 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00
04 01 03 03 08 09 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00
04 01 03 03 08 09 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00
04 01 03 03 08 09 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00
04 01 03 03 08 09 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00
04 01 03 03 08 09 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00
04 01 03 03 08 09 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00
04 01 03 03 08 09 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00
04 01 03 03 08 09 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00
04 01 03 03 08 09 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00
04 01 01 01 08 00 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00
04 09 01 01 0a 00 00 00 00 00  01 01 00 20 00 01 00  00 20 00 00 00 00 00 0a 00
04 09 01 01 0a 00 00 00 00 00  00 00 00 00 00 00 00  01 01 00 00 00 00 00 0a 00
05 02 00 00 00 00 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00
05 09 03 03 02 03 01 02 03 0a  00 00 00 00 00 00 00  01 21 22 20 21 03 0a 02 03
06 04 00 00 00 00 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00
06 09 03 03 01 02 03 04 05 06  00 00 00 00 00 00 00  01 20 21 03 04 05 06 01 02
ff 00 00 00 00 00 00 00 00 00  00 00 00 00 00 00 00  00 00 00 00 00 00 00 00 00

//--- tb.f
verilog/rename_pkg.sv
verilog/preg_free_list.sv
verilog/rename_map_table.sv
verilog/rename_group_bypass.sv
verilog/rename_unit.sv
verif/tb_rename_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rename unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_rename_unit -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    exit 0
fi
exit 1

//--- verif/tb_rename_unit.sv
`timescale 1ns/100ps

module tb_rename_unit;
    import rename_pkg::*;

    localparam int RW        = 2;
    localparam int CW        = 2;
    localparam int FIELDS    = 26;
    localparam int MAX_LINES = 64;
    localparam string PAT_FILE = "verif/rename_patterns.txt";

    logic          clk;
    logic          rst;
    logic          ren_vld;
    logic [RW-1:0] slot_vld;
    logic [RW-1:0] has_rd;
    arch_reg_t     ren_rd [RW];
    arch_reg_t     ren_rs1 [RW];
    arch_reg_t     ren_rs2 [RW];
    logic [CW-1:0] cmt_vld;
    arch_reg_t     cmt_rd [CW];
    phys_reg_t     cmt_prd [CW];
    phys_reg_t     cmt_old_prd [CW];
    logic          resteer;
    logic          flush;
    logic          ren_ready;
    phys_reg_t     prd [RW];
    phys_reg_t     prs1 [RW];
    phys_reg_t     prs2 [RW];
    phys_reg_t     old_prd [RW];

    // one byte per field, FIELDS bytes per pattern line
    logic [7:0] pat [FIELDS*MAX_LINES];
    int n_lines;
    int cycles;
    int errors;
    int test_errs;
    int tests_run;
    int tests_failed;

    rename_unit #(
        .RENAME_WIDTH (RW),
        .COMMIT_WIDTH (CW)
    ) dut0 (
        .clk            (clk),
        .i_rst          (rst),
        .i_ren_vld      (ren_vld),
        .i_ren_slot_vld (slot_vld),
        .i_ren_has_rd   (has_rd),
        .i_ren_rd       (ren_rd),
        .i_ren_rs1      (ren_rs1),
        .i_ren_rs2      (ren_rs2),
        .i_cmt_vld      (cmt_vld),
        .i_cmt_rd       (cmt_rd),
        .i_cmt_prd      (cmt_prd),
        .i_cmt_old_prd  (cmt_old_prd),
        .i_resteer      (resteer),
        .i_flush        (flush),
        .o_ren_ready    (ren_ready),
        .o_prd          (prd),
        .o_prs1         (prs1),
        .o_prs2         (prs2),
        .o_old_prd      (old_prd)
    );

    always #4 clk = ~clk;

    // run limit grows with the pattern count
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= n_lines + 50) begin
            $display("timeout after %0d cycles, pattern run did not finish", cycles);
            $display("tests failed");
            $finish;
        end
    end

    function automatic logic [7:0] field_at(input int ln, input int f);
        return pat[ln*FIELDS + f];
    endfunction

    task automatic check_preg(input string name, input phys_reg_t got, input phys_reg_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic drive_line(input int ln);
        logic [7:0] ctl;
        ctl = field_at(ln, 1);
        ren_vld  <= ctl[0];
        resteer  <= ctl[1];
        flush    <= ctl[2];
        slot_vld <= RW'(field_at(ln, 2));
        has_rd   <= RW'(field_at(ln, 3));
        cmt_vld  <= CW'(field_at(ln, 10));
        for (int k = 0; k < RW; k++) begin
            ren_rd[k]  <= arch_reg_t'(field_at(ln, 4 + k));
            ren_rs1[k] <= arch_reg_t'(field_at(ln, 6 + k));
            ren_rs2[k] <= arch_reg_t'(field_at(ln, 8 + k));
        end
        for (int c = 0; c < CW; c++) begin
            cmt_rd[c]      <= arch_reg_t'(field_at(ln, 11 + c));
            cmt_prd[c]     <= phys_reg_t'(field_at(ln, 13 + c));
            cmt_old_prd[c] <= phys_reg_t'(field_at(ln, 15 + c));
        end
    endtask

    task automatic check_line(input int ln);
        check_ready("o_ren_ready", ren_ready, 1'(field_at(ln, 17)));
        for (int k = 0; k < RW; k++) begin
            check_preg($sformatf("o_prd[%0d]", k), prd[k], phys_reg_t'(field_at(ln, 18 + k)));
            check_preg($sformatf("o_prs1[%0d]", k), prs1[k], phys_reg_t'(field_at(ln, 20 + k)));
            check_preg($sformatf("o_prs2[%0d]", k), prs2[k], phys_reg_t'(field_at(ln, 22 + k)));
            check_preg($sformatf("o_old_prd[%0d]", k), old_prd[k],
                       phys_reg_t'(field_at(ln, 24 + k)));
        end
    endtask

    task automatic report_test(input logic [7:0] id);
        tests_run++;
        if (test_errs == 0) begin
            $display("test %0d passed", id);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", id, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic run_patterns();
        logic [7:0] cur;
        logic [7:0] ctl;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        cur = field_at(0, 0);
        for (int ln = 0; ln < n_lines; ln++) begin
            if (field_at(ln, 0) != cur) begin
                report_test(cur);
                cur = field_at(ln, 0);
            end
            @(posedge clk);
            drive_line(ln);
            // rename outputs are combinational, settled by the falling edge
            @(negedge clk);
            ctl = field_at(ln, 1);
            if (ctl[3]) begin
                check_line(ln);
            end
        end
        report_test(cur);
        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    initial begin
        int fd;
        clk      = 1'b0;
        rst      = 1'b1;
        ren_vld  = 1'b0;
        slot_vld = '0;
        has_rd   = '0;
        cmt_vld  = '0;
        resteer  = 1'b0;
        flush    = 1'b0;
        for (int k = 0; k < RW; k++) begin
            ren_rd[k]  = '0;
            ren_rs1[k] = '0;
            ren_rs2[k] = '0;
        end
        for (int c = 0; c < CW; c++) begin
            cmt_rd[c]      = '0;
            cmt_prd[c]     = '0;
            cmt_old_prd[c] = '0;
        end
        cycles       = 0;
        errors       = 0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        n_lines      = 0;
        fd = $fopen(PAT_FILE, "r");
        if (fd == 0) begin
            $display("cannot open pattern file %s", PAT_FILE);
            $display("tests failed");
            $finish;
        end else begin
            $fclose(fd);
            $readmemh(PAT_FILE, pat);
            // test number ff marks the end of the list
            while (n_lines < MAX_LINES && field_at(n_lines, 0) != 8'hff) begin
                n_lines++;
            end
            run_patterns();
        end
    end

endmodule

//--- verilog/rename_unit.sv
`timescale 1ns/100ps

module rename_unit #(
    parameter int RENAME_WIDTH = 2,
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_ren_vld,
    input  logic [RENAME_WIDTH-1:0] i_ren_slot_vld,
    input  logic [RENAME_WIDTH-1:0] i_ren_has_rd,
    input  rename_pkg::arch_reg_t   i_ren_rd [RENAME_WIDTH],
    input  rename_pkg::arch_reg_t   i_ren_rs1 [RENAME_WIDTH],
    input  rename_pkg::arch_reg_t   i_ren_rs2 [RENAME_WIDTH],
    input  logic [COMMIT_WIDTH-1:0] i_cmt_vld,
    input  rename_pkg::arch_reg_t   i_cmt_rd [COMMIT_WIDTH],
    input  rename_pkg::phys_reg_t   i_cmt_prd [COMMIT_WIDTH],
    input  rename_pkg::phys_reg_t   i_cmt_old_prd [COMMIT_WIDTH],
    input  logic                    i_resteer,
    input  logic                    i_flush,
    output logic                    o_ren_ready,
    output rename_pkg::phys_reg_t   o_prd [RENAME_WIDTH],
    output rename_pkg::phys_reg_t   o_prs1 [RENAME_WIDTH],
    output rename_pkg::phys_reg_t   o_prs2 [RENAME_WIDTH],
    output rename_pkg::phys_reg_t   o_old_prd [RENAME_WIDTH]
);
    import rename_pkg::*;

    logic [RENAME_WIDTH-1:0] pop_req;
    logic                    pop_fire;
    phys_reg_t               pop_preg [RENAME_WIDTH];
    logic                    can_alloc;
    phys_reg_t               map_rs1 [RENAME_WIDTH];
    phys_reg_t               map_rs2 [RENAME_WIDTH];
    phys_reg_t               map_rd [RENAME_WIDTH];
    logic [RENAME_WIDTH-1:0] map_wr_en;
    phys_reg_t               map_wr_preg [RENAME_WIDTH];

    preg_free_list #(
        .RENAME_WIDTH (RENAME_WIDTH),
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) u_free_list (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_flush     (i_flush),
        .i_resteer   (i_resteer),
        .i_pop_req   (pop_req),
        .i_pop_fire  (pop_fire),
        .i_push_vld  (i_cmt_vld),
        .i_push_preg (i_cmt_old_prd),
        .o_can_alloc (can_alloc),
        .o_pop_avail (),
        .o_pop_preg  (pop_preg)
    );

    rename_map_table #(
        .RENAME_WIDTH (RENAME_WIDTH),
        .COMMIT_WIDTH (COMMIT_WIDTH)
    ) u_map_table (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_flush   (i_flush),
        .i_resteer (i_resteer),
        .i_rd_rs1  (i_ren_rs1),
        .i_rd_rs2  (i_ren_rs2),
        .i_rd_rd   (i_ren_rd),
        .o_map_rs1 (map_rs1),
        .o_map_rs2 (map_rs2),
        .o_map_rd  (map_rd),
        .i_wr_en   (map_wr_en),
        .i_wr_rd   (i_ren_rd),
        .i_wr_preg (map_wr_preg),
        .i_cmt_vld (i_cmt_vld),
        .i_cmt_rd  (i_cmt_rd),
        .i_cmt_prd (i_cmt_prd)
    );

    rename_group_bypass #(
        .RENAME_WIDTH (RENAME_WIDTH)
    ) u_bypass (
        .i_ren_vld     (i_ren_vld),
        .i_slot_vld    (i_ren_slot_vld),
        .i_has_rd      (i_ren_has_rd),
        .i_rd          (i_ren_rd),
        .i_rs1         (i_ren_rs1),
        .i_rs2         (i_ren_rs2),
        .i_map_rs1     (map_rs1),
        .i_map_rs2     (map_rs2),
        .i_map_rd      (map_rd),
        .i_pop_preg    (pop_preg),
        .i_can_alloc   (can_alloc),
        .o_pop_req     (pop_req),
        .o_pop_fire    (pop_fire),
        .o_map_wr_en   (map_wr_en),
        .o_map_wr_preg (map_wr_preg),
        .o_ren_ready   (o_ren_ready),
        .o_prd         (o_prd),
        .o_prs1        (o_prs1),
        .o_prs2        (o_prs2),
        .o_old_prd     (o_old_prd)
    );

endmodule

//--- verilog/rename_group_bypass.sv
`timescale 1ns/100ps

module rename_group_bypass #(
    parameter int RENAME_WIDTH = 2
) (
    input  logic                    i_ren_vld,
    input  logic [RENAME_WIDTH-1:0] i_slot_vld,
    input  logic [RENAME_WIDTH-1:0] i_has_rd,
    input  rename_pkg::arch_reg_t   i_rd [RENAME_WIDTH],
    input  rename_pkg::arch_reg_t   i_rs1 [RENAME_WIDTH],
    input  rename_pkg::arch_reg_t   i_rs2 [RENAME_WIDTH],
    input  rename_pkg::phys_reg_t   i_map_rs1 [RENAME_WIDTH],
    input  rename_pkg::phys_reg_t   i_map_rs2 [RENAME_WIDTH],
    input  rename_pkg::phys_reg_t   i_map_rd [RENAME_WIDTH],
    input  rename_pkg::phys_reg_t   i_pop_preg [RENAME_WIDTH],
    input  logic                    i_can_alloc,
    output logic [RENAME_WIDTH-1:0] o_pop_req,
    output logic                    o_pop_fire,
    output logic [RENAME_WIDTH-1:0] o_map_wr_en,
    output rename_pkg::phys_reg_t   o_map_wr_preg [RENAME_WIDTH],
    output logic                    o_ren_ready,
    output rename_pkg::phys_reg_t   o_prd [RENAME_WIDTH],
    output rename_pkg::phys_reg_t   o_prs1 [RENAME_WIDTH],
    output rename_pkg::phys_reg_t   o_prs2 [RENAME_WIDTH],
    output rename_pkg::phys_reg_t   o_old_prd [RENAME_WIDTH]
);
    import rename_pkg::*;

    localparam int CNT_W = $clog2(RENAME_WIDTH + 1);

    logic [RENAME_WIDTH-1:0] dst_vld;
    // destinations in the slots before each slot
    logic [CNT_W-1:0] dst_before [RENAME_WIDTH+1];
    phys_reg_t new_preg [RENAME_WIDTH];

    assign dst_vld       = i_slot_vld & i_has_rd;
    assign dst_before[0] = '0;
    assign o_ren_ready   = i_can_alloc;
    assign o_pop_fire    = i_ren_vld & i_can_alloc;

    for (genvar k = 0; k < RENAME_WIDTH; k++) begin : gen_slot
        assign dst_before[k+1] = dst_before[k] + CNT_W'(dst_vld[k]);
        assign o_pop_req[k]    = CNT_W'(k) < dst_before[RENAME_WIDTH];

        // k-th destination takes free-list port k
        always_comb begin
            new_preg[k] = '0;
            for (int p = 0; p < RENAME_WIDTH; p++) begin
                if (dst_vld[k] && dst_before[k] == CNT_W'(p)) begin
                    new_preg[k] = i_pop_preg[p];
                end
            end
        end

        // youngest older writer wins, so scan oldest first
        always_comb begin
            o_prs1[k]    = i_map_rs1[k];
            o_prs2[k]    = i_map_rs2[k];
            o_old_prd[k] = i_map_rd[k];
            for (int j = 0; j < k; j++) begin
                if (dst_vld[j] && i_rd[j] == i_rs1[k]) begin
                    o_prs1[k] = new_preg[j];
                end
                if (dst_vld[j] && i_rd[j] == i_rs2[k]) begin
                    o_prs2[k] = new_preg[j];
                end
                if (dst_vld[j] && i_rd[j] == i_rd[k]) begin
                    o_old_prd[k] = new_preg[j];
                end
            end
        end

        assign o_prd[k]         = new_preg[k];
        assign o_map_wr_en[k]   = o_pop_fire & dst_vld[k];
        assign o_map_wr_preg[k] = new_preg[k];
    end

endmodule

//--- verilog/rename_map_table.sv
`timescale 1ns/100ps

module rename_map_table #(
    parameter int RENAME_WIDTH = 2,
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_flush,
    input  logic                    i_resteer,
    input  rename_pkg::arch_reg_t   i_rd_rs1 [RENAME_WIDTH],
    input  rename_pkg::arch_reg_t   i_rd_rs2 [RENAME_WIDTH],
    input  rename_pkg::arch_reg_t   i_rd_rd [RENAME_WIDTH],
    output rename_pkg::phys_reg_t   o_map_rs1 [RENAME_WIDTH],
    output rename_pkg::phys_reg_t   o_map_rs2 [RENAME_WIDTH],
    output rename_pkg::phys_reg_t   o_map_rd [RENAME_WIDTH],
    input  logic [RENAME_WIDTH-1:0] i_wr_en,
    input  rename_pkg::arch_reg_t   i_wr_rd [RENAME_WIDTH],
    input  rename_pkg::phys_reg_t   i_wr_preg [RENAME_WIDTH],
    input  logic [COMMIT_WIDTH-1:0] i_cmt_vld,
    input  rename_pkg::arch_reg_t   i_cmt_rd [COMMIT_WIDTH],
    input  rename_pkg::phys_reg_t   i_cmt_prd [COMMIT_WIDTH]
);
    import rename_pkg::*;

    phys_reg_t spec_map [ARCH_REGS];
    phys_reg_t arch_map [ARCH_REGS];

    for (genvar k = 0; k < RENAME_WIDTH; k++) begin : gen_read
        assign o_map_rs1[k] = spec_map[i_rd_rs1[k]];
        assign o_map_rs2[k] = spec_map[i_rd_rs2[k]];
        assign o_map_rd[k]  = spec_map[i_rd_rd[k]];
    end

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                spec_map[r] <= phys_reg_t'(r);
            end
        end else if (i_resteer) begin
            spec_map <= arch_map;
        end else begin
            // later slot overrides an earlier one on the same rd
            for (int k = 0; k < RENAME_WIDTH; k++) begin
                if (i_wr_en[k]) begin
                    spec_map[i_wr_rd[k]] <= i_wr_preg[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                arch_map[r] <= phys_reg_t'(r);
            end
        end else begin
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                if (i_cmt_vld[c]) begin
                    arch_map[i_cmt_rd[c]] <= i_cmt_prd[c];
                end
            end
        end
    end

    // copy would miss this cycle's commits
    assert property (@(posedge clk) disable iff (i_rst)
        !(i_resteer && (|i_cmt_vld)));

endmodule

//--- verilog/preg_free_list.sv
`timescale 1ns/100ps

module preg_free_list #(
    parameter int RENAME_WIDTH = 2,
    parameter int COMMIT_WIDTH = 2
) (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_flush,
    input  logic                   i_resteer,
    input  logic [RENAME_WIDTH-1:0] i_pop_req,
    input  logic                   i_pop_fire,
    input  logic [COMMIT_WIDTH-1:0] i_push_vld,
    input  rename_pkg::phys_reg_t  i_push_preg [COMMIT_WIDTH],
    output logic                   o_can_alloc,
    output logic [RENAME_WIDTH-1:0] o_pop_avail,
    output rename_pkg::phys_reg_t  o_pop_preg [RENAME_WIDTH]
);
    import rename_pkg::*;

    localparam int PTR_W = $clog2(FREE_DEPTH);
    localparam int SUM_W = PTR_W + 1;

    typedef logic [PTR_W-1:0] ptr_t;

    phys_reg_t buffer [FREE_DEPTH];
    ptr_t      rd_ptr [RENAME_WIDTH];
    ptr_t      wr_ptr [COMMIT_WIDTH];
    free_cnt_t cnt;
    ptr_t      arch_rd_ptr;

    logic [RENAME_WIDTH-1:0] pop_mask;
    free_cnt_t pop_num;
    free_cnt_t push_num;

    // pointer advance with wrap at FREE_DEPTH
    function automatic ptr_t ptr_add(input ptr_t p, input free_cnt_t n);
        logic [SUM_W-1:0] s;
        s = {1'b0, p} + SUM_W'(n);
        if (s >= SUM_W'(FREE_DEPTH)) begin
            s = s - SUM_W'(FREE_DEPTH);
        end
        return s[PTR_W-1:0];
    endfunction

    assign pop_mask = i_pop_fire ? i_pop_req : '0;
    assign pop_num  = count_ones(slot_mask_t'(pop_mask));
    assign push_num = count_ones(slot_mask_t'(i_push_vld));

    for (genvar k = 0; k < RENAME_WIDTH; k++) begin : gen_port
        assign o_pop_avail[k] = free_cnt_t'(k) < cnt;
        assign o_pop_preg[k]  = buffer[rd_ptr[k]];
    end

    // request is contiguous, so checking the ports it touches is enough
    assign o_can_alloc = (i_pop_req & ~o_pop_avail) == '0;

    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                buffer[i] <= phys_reg_t'(PHYS_REGS - FREE_DEPTH + i);
            end
            for (int k = 0; k < RENAME_WIDTH; k++) begin
                rd_ptr[k] <= ptr_t'(k);
            end
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                wr_ptr[c] <= ptr_t'(c);
            end
            cnt <= free_cnt_t'(FREE_DEPTH);
        end else if (i_resteer) begin
            // every committed pop has already been pushed back
            cnt <= free_cnt_t'(FREE_DEPTH);
            for (int k = 0; k < RENAME_WIDTH; k++) begin
                rd_ptr[k] <= ptr_add(arch_rd_ptr, free_cnt_t'(k));
            end
        end else begin
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                if (i_push_vld[c]) begin
                    buffer[wr_ptr[c]] <= i_push_preg[c];
                end
                wr_ptr[c] <= ptr_add(wr_ptr[c], push_num);
            end
            for (int k = 0; k < RENAME_WIDTH; k++) begin
                rd_ptr[k] <= ptr_add(rd_ptr[k], pop_num);
            end
            cnt <= cnt + push_num - pop_num;
        end
    end

    // committed view, the restore point for resteer
    always_ff @(posedge clk) begin
        if (i_rst || i_flush) begin
            arch_rd_ptr <= '0;
        end else begin
            // each commit slot retires one earlier pop
            arch_rd_ptr <= ptr_add(arch_rd_ptr, push_num);
        end
    end

    assert property (@(posedge clk) disable iff (i_rst)
        cnt <= free_cnt_t'(FREE_DEPTH));

    assert property (@(posedge clk) disable iff (i_rst)
        (i_pop_req & (i_pop_req + 1'b1)) == '0);

    assert property (@(posedge clk) disable iff (i_rst)
        (i_push_vld & (i_push_vld + 1'b1)) == '0);

    assert property (@(posedge clk) disable iff (i_rst)
        i_pop_fire |-> o_can_alloc);

    // restore would drop the pushed registers
    assert property (@(posedge clk) disable iff (i_rst)
        !(i_resteer && (|i_push_vld)));

endmodule

//--- verilog/rename_pkg.sv
package rename_pkg;

    localparam int ARCH_REGS  = 32;
    localparam int PHYS_REGS  = 64;
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;

    // widest rename or commit group supported
    localparam int MAX_SLOTS = 4;

    typedef logic [4:0] arch_reg_t;
    typedef logic [5:0] phys_reg_t;
    typedef logic [5:0] free_cnt_t;
    typedef logic [MAX_SLOTS-1:0] slot_mask_t;

    // population count of a slot mask
    function automatic free_cnt_t count_ones(input slot_mask_t mask);
        free_cnt_t n;
        n = '0;
        for (int i = 0; i < MAX_SLOTS; i++) begin
            n = n + free_cnt_t'(mask[i]);
        end
        return n;
    endfunction

endpackage
